// ==== filelist.f ====
alloc_pkg.sv
rr_arbiter.sv
sw_alloc_stage.sv
ovc_select.sv
spec_merge.sv
comb_spec_alloc.sv
tb_comb_spec_alloc.sv

// ==== Bender.yml ====
package:
  name: comb_spec_alloc

sources:
  - files:
      - alloc_pkg.sv
      - rr_arbiter.sv
      - sw_alloc_stage.sv
      - ovc_select.sv
      - spec_merge.sv
      - comb_spec_alloc.sv
  - target: test
    files:
      - tb_comb_spec_alloc.sv

// ==== tb_comb_spec_alloc.sv ====
`default_nettype none

module tb_comb_spec_alloc
    import alloc_pkg::*;
();

    typedef enum logic [2:0] {
        PH_IDLE, PH_RANDOM, PH_CONTEND, PH_LONE_SPEC, PH_LONE_FULL, PH_FAIR
    } phase_e;

    logic        clk;
    logic        arst_n;
    port_req_t   port_req [NUM_PORTS];
    port_grant_t port_grant [NUM_PORTS];
    vc_vec_t     ovc_allocated [NUM_PORTS];

    phase_e      phase;
    logic [31:0] lfsr_state;
    int          err_count;
    int          test_count;

    // reference view of the grants, rebuilt from the requests every cycle
    vc_vec_t              gnt_mask [NUM_PORTS];   // candidate ovcs of the granted vc
    dest_vec_t            exp_dest [NUM_PORTS];
    logic [NUM_PORTS-1:0] claims [NUM_PORTS];     // inputs naming each output
    vc_vec_t              exp_alloc [NUM_PORTS];
    logic                 any_req;
    logic                 any_out;
    logic                 won0;
    logic                 won2;

    comb_spec_alloc dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .port_req      (port_req),
        .port_grant    (port_grant),
        .ovc_allocated (ovc_allocated)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // destination bit d at input in_port skips the input's own port
    function automatic int out_of_dest(int in_port, int d);
        int o;
        o = d;
        if (o >= in_port) begin
            o = o + 1;
        end
        return o;
    endfunction

    always_comb begin
        int o;
        any_req = 1'b0;
        any_out = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            gnt_mask[p]  = '0;
            exp_dest[p]  = '0;
            claims[p]    = '0;
            exp_alloc[p] = '0;
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            any_req = any_req | (port_req[i].ivc_request != '0);
            any_out = any_out | (port_grant[i] != '0) | (ovc_allocated[i] != '0);
            for (int v = 0; v < NUM_VCS; v++) begin
                if (port_grant[i].ivc_sw_grant[v]) begin
                    gnt_mask[i] = gnt_mask[i] | port_req[i].masked_ovc_request[v];
                    exp_dest[i] = exp_dest[i] | port_req[i].dest_port[v];
                end
            end
            for (int d = 0; d < NUM_DEST; d++) begin
                if (port_grant[i].granted_dest[d]) begin
                    o = out_of_dest(i, d);
                    claims[o][i] = 1'b1;
                    if (port_grant[i].ivc_ovc_grant != '0) begin
                        exp_alloc[o] = exp_alloc[o] | port_grant[i].granted_ovc;
                    end
                end
            end
        end
    end

    assign won0 = (port_grant[0].ivc_sw_grant != '0);
    assign won2 = (port_grant[2].ivc_sw_grant != '0);

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
        a_sw_legal : assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(port_grant[i].ivc_sw_grant)
            && ((port_grant[i].ivc_sw_grant & ~port_req[i].ivc_request) == '0))
        else begin
            $display("[ERROR] port_grant[%0d].ivc_sw_grant=%h ivc_request=%h", i,
                     $sampled(port_grant[i].ivc_sw_grant), $sampled(port_req[i].ivc_request));
            err_count++;
        end

        a_not_full : assert property (@(posedge clk) disable iff (!arst_n)
            (port_grant[i].ivc_sw_grant & port_req[i].ovc_is_assigned
             & ~port_req[i].assigned_ovc_not_full) == '0)
        else begin
            $display("[ERROR] port_grant[%0d].ivc_sw_grant=%h assigned_ovc_not_full=%h", i,
                     $sampled(port_grant[i].ivc_sw_grant),
                     $sampled(port_req[i].assigned_ovc_not_full));
            err_count++;
        end

        a_dest_match : assert property (@(posedge clk) disable iff (!arst_n)
            port_grant[i].granted_dest == exp_dest[i])
        else begin
            $display("[ERROR] port_grant[%0d].granted_dest=%h expected=%h", i,
                     $sampled(port_grant[i].granted_dest), $sampled(exp_dest[i]));
            err_count++;
        end

        a_ovc_match : assert property (@(posedge clk) disable iff (!arst_n)
            (port_grant[i].ivc_ovc_grant == '0)
            || (port_grant[i].ivc_ovc_grant == port_grant[i].ivc_sw_grant))
        else begin
            $display("[ERROR] port_grant[%0d].ivc_ovc_grant=%h ivc_sw_grant=%h", i,
                     $sampled(port_grant[i].ivc_ovc_grant),
                     $sampled(port_grant[i].ivc_sw_grant));
            err_count++;
        end

        // speculative vc with a legal ovc from its candidates
        a_ovc_legal : assert property (@(posedge clk) disable iff (!arst_n)
            (port_grant[i].ivc_ovc_grant != '0) |->
                (((port_grant[i].ivc_ovc_grant & port_req[i].ovc_is_assigned) == '0)
                 && $onehot(port_grant[i].granted_ovc)
                 && ((port_grant[i].granted_ovc & ~gnt_mask[i]) == '0)))
        else begin
            $display("[ERROR] port_grant[%0d].granted_ovc=%h candidates=%h", i,
                     $sampled(port_grant[i].granted_ovc), $sampled(gnt_mask[i]));
            err_count++;
        end

        a_out_excl : assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(claims[i]))
        else begin
            $display("output %0d was granted to more than one input (inputs %h)", i,
                     $sampled(claims[i]));
            err_count++;
        end

        a_alloc_map : assert property (@(posedge clk) disable iff (!arst_n)
            ovc_allocated[i] == exp_alloc[i])
        else begin
            $display("[ERROR] ovc_allocated[%0d]=%h expected=%h", i,
                     $sampled(ovc_allocated[i]), $sampled(exp_alloc[i]));
            err_count++;
        end
    end

    a_idle : assert property (@(posedge clk) !any_req |-> !any_out)
    else begin
        $display("a grant appeared while no request was pending");
        err_count++;
    end

    a_priority : assert property (@(posedge clk) disable iff (!arst_n)
        (phase == PH_CONTEND) |-> (won0 && !won2))
    else begin
        $display("speculative input 2 was not held back by non-speculative input 0");
        err_count++;
    end

    a_lone_spec : assert property (@(posedge clk) disable iff (!arst_n)
        (phase == PH_LONE_SPEC) |-> ((port_grant[3].ivc_sw_grant == 4'b0100)
                                     && (port_grant[3].ivc_ovc_grant == 4'b0100)))
    else begin
        $display("[ERROR] port_grant[3].ivc_sw_grant=%h ivc_ovc_grant=%h expected=%h",
                 $sampled(port_grant[3].ivc_sw_grant),
                 $sampled(port_grant[3].ivc_ovc_grant), 4'h4);
        err_count++;
    end

    a_lone_full : assert property (@(posedge clk) disable iff (!arst_n)
        (phase == PH_LONE_FULL) |-> !any_out)
    else begin
        $display("a request whose output VC is full was granted");
        err_count++;
    end

    a_fair : assert property (@(posedge clk) disable iff (!arst_n)
        ((phase == PH_FAIR) && ($past(phase) == PH_FAIR)) |->
            ((won0 || $past(won0)) && (won2 || $past(won2))))
    else begin
        $display("input 0 or input 2 went two cycles in a row without a grant");
        err_count++;
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic port_req_t random_req();
        port_req_t r;
        r = '0;
        r.ivc_request           = vc_vec_t'(take_bits(NUM_VCS));
        r.ovc_is_assigned       = vc_vec_t'(take_bits(NUM_VCS));
        r.assigned_ovc_not_full = vc_vec_t'(take_bits(NUM_VCS));
        for (int v = 0; v < NUM_VCS; v++) begin
            r.dest_port[v]          = dest_vec_t'(1) << take_bits($clog2(NUM_DEST));
            r.masked_ovc_request[v] = vc_vec_t'(take_bits(NUM_VCS));
        end
        return r;
    endfunction

    function automatic port_req_t make_req(int vc, dest_vec_t dest, bit assigned,
                                           bit not_full, vc_vec_t mask);
        port_req_t r;
        r = '0;
        r.ivc_request[vc]           = 1'b1;
        r.ovc_is_assigned[vc]       = assigned;
        r.assigned_ovc_not_full[vc] = not_full;
        r.dest_port[vc]             = dest;
        r.masked_ovc_request[vc]    = mask;
        return r;
    endfunction

    task automatic drive_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_req[p] <= '0;
        end
    endtask

    // drop requests, let the last cycle's checks run, then report
    task automatic finish_test(string name, int start_err);
        @(posedge clk);
        phase <= PH_IDLE;
        drive_idle();
        @(negedge clk);
        test_count++;
        $display("test %s %s (%0d errors)", name,
                 (err_count == start_err) ? "ok" : "failed", err_count - start_err);
    endtask

    task automatic wait_ovc_grant(int port, int limit);
        bit seen;
        seen = 1'b0;
        for (int t = 0; t < limit && !seen; t++) begin
            @(negedge clk);
            seen = (port_grant[port].ivc_ovc_grant != '0);
        end
        if (!seen) begin
            $display("timeout: input %0d never received an output VC", port);
            err_count++;
        end
    endtask

    initial begin
        int start_err;
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_req[p] = '0;
        end
        arst_n     = 1'b0;
        phase      = PH_IDLE;
        lfsr_state = 32'd95720;
        err_count  = 0;
        test_count = 0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        start_err = err_count;
        repeat (400) begin
            @(posedge clk);
            phase <= PH_RANDOM;
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_req[p] <= random_req();
            end
        end
        finish_test("random traffic", start_err);

        // input 0 non-spec and input 2 spec, both toward output 1
        start_err = err_count;
        @(posedge clk);
        phase       <= PH_CONTEND;
        port_req[0] <= make_req(1, 4'b0001, 1'b1, 1'b1, 4'b0000);
        port_req[2] <= make_req(3, 4'b0010, 1'b0, 1'b0, 4'b0110);
        repeat (12) @(posedge clk);
        finish_test("directed contention", start_err);

        start_err = err_count;
        @(posedge clk);
        phase       <= PH_LONE_SPEC;
        port_req[3] <= make_req(2, 4'b1000, 1'b0, 1'b0, 4'b1010);
        wait_ovc_grant(3, 8);
        repeat (3) @(posedge clk);
        finish_test("lone speculative request", start_err);

        start_err = err_count;
        @(posedge clk);
        phase       <= PH_LONE_FULL;
        port_req[1] <= make_req(1, 4'b0100, 1'b1, 1'b0, 4'b0011);
        repeat (6) @(posedge clk);
        finish_test("lone request to full ovc", start_err);

        start_err = err_count;
        @(posedge clk);
        phase       <= PH_FAIR;
        port_req[0] <= make_req(0, 4'b0001, 1'b1, 1'b1, 4'b0000);
        port_req[2] <= make_req(2, 4'b0010, 1'b1, 1'b1, 4'b0000);
        repeat (16) @(posedge clk);
        finish_test("round-robin fairness", start_err);

        $display("%0d tests run, %0d failed checks", test_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== comb_spec_alloc.sv ====
`default_nettype none

module comb_spec_alloc
    import alloc_pkg::*;
(
    input  wire               clk,
    input  wire               arst_n,
    input  wire  port_req_t   port_req [NUM_PORTS],
    output port_grant_t       port_grant [NUM_PORTS],
    output vc_vec_t           ovc_allocated [NUM_PORTS]
);

    stage_out_t           nonspec_out [NUM_PORTS];
    stage_out_t           spec_out [NUM_PORTS];
    logic [NUM_PORTS-1:0] nonspec_out_granted;
    vc_vec_t              spec_winner [NUM_PORTS];
    vc_vec_t              ovc_choice [NUM_PORTS];
    logic [NUM_PORTS-1:0] valid_spec;

    sw_alloc_stage #(
        .SPECULATIVE (1'b0)
    ) nonspec_alloc_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .port_req    (port_req),
        .stage_out   (nonspec_out),
        .out_granted (nonspec_out_granted)
    );

    sw_alloc_stage #(
        .SPECULATIVE (1'b1)
    ) spec_alloc_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .port_req    (port_req),
        .stage_out   (spec_out),
        .out_granted ()             // outputs lost to non-spec come from the other stage
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_win
        assign spec_winner[i] = spec_out[i].first_winner;
    end

    ovc_select ovc_select_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .port_req    (port_req),
        .spec_winner (spec_winner),
        .ovc_choice  (ovc_choice),
        .valid_spec  (valid_spec)
    );

    spec_merge spec_merge_i (
        .nonspec             (nonspec_out),
        .nonspec_out_granted (nonspec_out_granted),
        .spec                (spec_out),
        .ovc_choice          (ovc_choice),
        .valid_spec          (valid_spec),
        .clk                 (clk),
        .port_grant          (port_grant),
        .ovc_allocated       (ovc_allocated)
    );

endmodule

`default_nettype wire

// ==== spec_merge.sv ====
`default_nettype none

module spec_merge
    import alloc_pkg::*;
(
    input  wire  stage_out_t           nonspec [NUM_PORTS],
    input  wire  [NUM_PORTS-1:0]       nonspec_out_granted,
    input  wire  stage_out_t           spec [NUM_PORTS],
    input  wire  vc_vec_t              ovc_choice [NUM_PORTS],
    input  wire  [NUM_PORTS-1:0]       valid_spec,
    input  wire                        clk,
    output port_grant_t                port_grant [NUM_PORTS],
    output vc_vec_t                    ovc_allocated [NUM_PORTS]
);

    dest_vec_t            spec_ok [NUM_PORTS];    // surviving speculative dest grants
    logic [NUM_PORTS-1:0] spec_win;
    logic [NUM_PORTS-1:0] alloc_src [NUM_PORTS];  // inputs writing each output's ovcs

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            spec_ok[i] = '0;
            // input and output must both be free of non-spec traffic
            if (!nonspec[i].in_granted && valid_spec[i]) begin
                for (int d = 0; d < NUM_DEST; d++) begin
                    spec_ok[i][d] = spec[i].dest_grant[d]
                                  & ~nonspec_out_granted[dest_to_port(i, d)];
                end
            end
            spec_win[i] = |spec_ok[i];
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_grant
        assign port_grant[i].ivc_sw_grant  = nonspec[i].ivc_grant
                                           | (spec_win[i] ? spec[i].ivc_grant : '0);
        assign port_grant[i].granted_dest  = nonspec[i].dest_grant | spec_ok[i];
        assign port_grant[i].ivc_ovc_grant = spec_win[i] ? spec[i].ivc_grant : '0;
        assign port_grant[i].granted_ovc   = spec_win[i] ? ovc_choice[i] : '0;
    end

    // mark the chosen ovc at the output each surviving input won
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            ovc_allocated[o] = '0;
            alloc_src[o]     = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (i != o && spec_ok[i][port_to_dest(i, o)]) begin
                    ovc_allocated[o] = ovc_allocated[o] | ovc_choice[i];
                    alloc_src[o][i]  = 1'b1;
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
        a_no_double_grant : assert property (@(posedge clk)
            !((nonspec[i].dest_grant != '0) && (spec_ok[i] != '0)));

        a_ovc_single_src : assert property (@(posedge clk)
            $onehot0(alloc_src[i]));
    end

endmodule

`default_nettype wire

// ==== ovc_select.sv ====
`default_nettype none

module ovc_select
    import alloc_pkg::*;
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire  port_req_t      port_req [NUM_PORTS],
    input  wire  vc_vec_t        spec_winner [NUM_PORTS],
    output vc_vec_t              ovc_choice [NUM_PORTS],
    output logic [NUM_PORTS-1:0] valid_spec
);

    vc_vec_t cand [NUM_PORTS];  // candidate ovcs of the winning input vc

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand[i] = '0;
            for (int v = 0; v < NUM_VCS; v++) begin
                if (spec_winner[i][v]) begin
                    cand[i] = cand[i] | port_req[i].masked_ovc_request[v];
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        // one ovc per input, picked before the switch result is known
        rr_arbiter #(
            .WIDTH (NUM_VCS)
        ) ovc_arb_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (cand[i]),
            .grant     (ovc_choice[i]),
            .any_grant (valid_spec[i])
        );
    end

endmodule

`default_nettype wire

// ==== sw_alloc_stage.sv ====
`default_nettype none

module sw_alloc_stage
    import alloc_pkg::*;
#(
    parameter bit SPECULATIVE = 1'b0
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire  port_req_t      port_req [NUM_PORTS],
    output stage_out_t           stage_out [NUM_PORTS],
    output logic [NUM_PORTS-1:0] out_granted
);

    vc_vec_t              in_req   [NUM_PORTS];  // request class per input
    vc_vec_t              in_win   [NUM_PORTS];  // input arbiter winners
    dest_vec_t            win_dest [NUM_PORTS];  // destination of each winner
    dest_vec_t            out_req  [NUM_PORTS];  // per output, bit per other input
    dest_vec_t            out_gnt  [NUM_PORTS];
    dest_vec_t            dest_gnt [NUM_PORTS];  // per input, bit per destination
    logic [NUM_PORTS-1:0] out_owner [NUM_PORTS]; // inputs holding each output

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        if (SPECULATIVE) begin : g_spec
            // no ovc yet, so fullness is unknown
            assign in_req[i] = port_req[i].ivc_request & ~port_req[i].ovc_is_assigned;
        end else begin : g_nonspec
            assign in_req[i] = port_req[i].ivc_request & port_req[i].ovc_is_assigned
                             & port_req[i].assigned_ovc_not_full;
        end

        rr_arbiter #(
            .WIDTH (NUM_VCS)
        ) in_arb_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (in_req[i]),
            .grant     (in_win[i]),
            .any_grant ()
        );

        rr_arbiter #(
            .WIDTH (NUM_DEST)
        ) out_arb_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (out_req[i]),  // i is the output here
            .grant     (out_gnt[i]),
            .any_grant (out_granted[i])
        );
    end

    // one-hot mux of the winner's destination
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            win_dest[i] = '0;
            for (int v = 0; v < NUM_VCS; v++) begin
                if (in_win[i][v]) begin
                    win_dest[i] = win_dest[i] | port_req[i].dest_port[v];
                end
            end
        end
    end

    // swap between input-relative and output-relative indexing
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_req[o]   = '0;
            dest_gnt[o]  = '0;
            out_owner[o] = '0;
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (j != o) begin
                    out_req[o][port_to_dest(o, j)]  = win_dest[j][port_to_dest(j, o)];
                    dest_gnt[j][port_to_dest(j, o)] = out_gnt[o][port_to_dest(o, j)];
                    out_owner[o][j]                 = out_gnt[o][port_to_dest(o, j)];
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_out
        assign stage_out[i].first_winner = in_win[i];
        assign stage_out[i].dest_grant   = dest_gnt[i];
        assign stage_out[i].in_granted   = |dest_gnt[i];
        assign stage_out[i].ivc_grant    = (|dest_gnt[i]) ? in_win[i] : '0;

        a_out_exclusive : assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(out_owner[i]) && (out_granted[i] == (|out_owner[i])));
    end

endmodule

`default_nettype wire

// ==== rr_arbiter.sv ====
`default_nettype none

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  wire              clk,
    input  wire              arst_n,
    input  wire  [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [PTR_W-1:0] ptr;      // highest priority index
    logic [PTR_W-1:0] win_idx;
    logic             found;

    // scan from the pointer upward, wrapping once
    always_comb begin
        int idx;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int k = 0; k < WIDTH; k++) begin
            idx = int'(ptr) + k;
            if (idx >= WIDTH) begin
                idx = idx - WIDTH;
            end
            if (request[idx] && !found) begin
                grant[idx] = 1'b1;
                win_idx    = PTR_W'(idx);
                found      = 1'b1;
            end
        end
    end

    assign any_grant = found;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (found) begin
            // the index after the winner goes first next time
            ptr <= (win_idx == PTR_W'(WIDTH - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    a_grant_legal : assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && ((grant & ~request) == '0));

endmodule

`default_nettype wire

// ==== alloc_pkg.sv ====
`default_nettype none

package alloc_pkg;

    localparam int NUM_PORTS = 5;
    localparam int NUM_VCS   = 4;
    localparam int NUM_DEST  = NUM_PORTS - 1;  // a port never targets itself

    typedef logic [NUM_VCS-1:0]  vc_vec_t;
    typedef logic [NUM_DEST-1:0] dest_vec_t;

    // what one input port presents each cycle
    typedef struct packed {
        vc_vec_t                  ivc_request;
        vc_vec_t                  ovc_is_assigned;
        vc_vec_t                  assigned_ovc_not_full;
        dest_vec_t [NUM_VCS-1:0]  dest_port;           // one-hot per vc
        vc_vec_t   [NUM_VCS-1:0]  masked_ovc_request;  // candidate ovcs per vc
    } port_req_t;

    // what one input port gets back
    typedef struct packed {
        vc_vec_t   ivc_sw_grant;
        vc_vec_t   ivc_ovc_grant;
        vc_vec_t   granted_ovc;
        dest_vec_t granted_dest;
    } port_grant_t;

    // per-input result of one separable allocator stage
    typedef struct packed {
        vc_vec_t   first_winner;
        vc_vec_t   ivc_grant;
        dest_vec_t dest_grant;
        logic      in_granted;
    } stage_out_t;

    // destination bit d at input in_port -> output port number
    function automatic int dest_to_port(int in_port, int dest);
        return (dest < in_port) ? dest : dest + 1;
    endfunction

    // output port number -> destination bit at input in_port (out_port != in_port)
    function automatic int port_to_dest(int in_port, int out_port);
        return (out_port < in_port) ? out_port : out_port - 1;
    endfunction

endpackage

`default_nettype wire
